// File: cmul.f
+incdir+rtl
rtl/cmul_pkg.sv
rtl/cmul_sequencer.sv
rtl/mul_step_counter.sv
rtl/shift_add_datapath.sv
rtl/cmul_operand_regs.sv
rtl/cmul_top.sv
dv/cmul_checker.sv
dv/cmul_monitor.sv
dv/cmul_tb.sv

// File: dv/cmul_checker.sv
module cmul_checker (
	input  logic           clk,
	input  logic           reset,
	input  logic           recv_rdy,
	input  logic           send_val,
	input  logic           send_rdy,
	input  cmul_pkg::fix_t cr,
	input  cmul_pkg::fix_t cc
);
	timeunit 1ns;
	timeprecision 1ps;

	// only one transaction is in flight, so the two sides never open together.
	rdy_val_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(recv_rdy && send_val))
		else $error("recv_rdy and send_val are high in the same cycle");

	// a result under back-pressure stays put until it is taken.
	result_held: assert property (@(posedge clk) disable iff (reset)
		send_val && !send_rdy |=> send_val && $stable(cr) && $stable(cc))
		else $error("result changed while send_rdy was low");

	ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> recv_rdy)
		else $error("recv_rdy is low in the first cycle after reset");

endmodule

// File: dv/cmul_monitor.sv
`include "cmul_settings.svh"

module cmul_monitor (
	input  logic           clk,
	input  logic           reset,
	input  logic           recv_val,
	input  logic           recv_rdy,
	input  logic           send_val,
	input  logic           send_rdy,
	input  cmul_pkg::fix_t cr,
	input  cmul_pkg::fix_t cc,
	input  cmul_pkg::fix_t exp_cr,
	input  cmul_pkg::fix_t exp_cc,
	output int             checked,
	output int             errors
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LATENCY = 3 * (`CMUL_N + 1); // N+1 steps for each of three products.

	logic           busy;
	logic           seen_val;
	logic           after_reset;
	logic           holding;
	int             cycles;
	int             test_num;
	int             accepted;
	int             test_errors;
	cmul_pkg::fix_t want_cr;
	cmul_pkg::fix_t want_cc;
	cmul_pkg::fix_t held_cr;
	cmul_pkg::fix_t held_cc;

	task report_error(input string msg);
		$display("ERROR at %0d ns: test %0d: %s", $time, test_num, msg);
		errors++;
		test_errors++;
	endtask

	initial begin
		checked     = 0;
		errors      = 0;
		accepted    = 0;
		test_num    = 0;
		test_errors = 0;
		busy        = 1'b0;
		seen_val    = 1'b0;
		after_reset = 1'b0;
		holding     = 1'b0;
		cycles      = 0;
	end

	// the falling edge sits halfway between input changes and state updates.
	always @(negedge clk) begin
		if (reset) begin
			busy        = 1'b0;
			holding     = 1'b0;
			after_reset = 1'b1;
		end else begin
			if (after_reset && (!recv_rdy || send_val))
				report_error("recv_rdy or send_val wrong after reset");
			after_reset = 1'b0;
			if (recv_rdy && send_val)
				report_error("recv_rdy and send_val high together");
			if (busy && recv_rdy)
				report_error("recv_rdy high with a transaction in flight");
			if (send_val && !busy)
				report_error("send_val high with no transaction in flight");
			if (holding && (!send_val || cr !== held_cr || cc !== held_cc))
				report_error("result changed while send_rdy was low");
			if (busy && !send_val)
				cycles++;
			else if (busy && !seen_val) begin
				seen_val = 1'b1;
				if (cycles != LATENCY)
					report_error($sformatf("latency %0d cycles, expected %0d", cycles, LATENCY));
			end
			if (busy && send_val && send_rdy) begin
				if (cr !== want_cr)
					report_error($sformatf("cr is %h, expected %h", cr, want_cr));
				if (cc !== want_cc)
					report_error($sformatf("cc is %h, expected %h", cc, want_cc));
				if (test_errors == 0)
					$display("test %0d passed: cr=%h cc=%h", test_num, cr, cc);
				else
					$display("test %0d failed with %0d errors", test_num, test_errors);
				checked++;
				busy = 1'b0;
			end
			if (recv_val && recv_rdy) begin
				busy        = 1'b1; // operands are taken on the coming edge.
				seen_val    = 1'b0;
				cycles      = 0;
				test_num    = accepted;
				test_errors = 0;
				want_cr     = exp_cr;
				want_cc     = exp_cc;
				accepted++;
			end
			holding = send_val && !send_rdy;
			held_cr = cr;
			held_cc = cc;
		end
	end

endmodule

// File: dv/cmul_tb.sv
`include "cmul_settings.svh"

module cmul_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TABLE    = 9;
	localparam int NUM_RANDOM   = 12;
	localparam int NUM_TESTS    = NUM_TABLE + NUM_RANDOM;
	localparam int MAX_HOLD     = 7;
	localparam int RESET_CYCLES = 5;
	localparam int TEST_CYCLES  = 3 * (`CMUL_N + 1) + MAX_HOLD + 10;

	logic           clk;
	logic           reset;
	logic           recv_val;
	logic           recv_rdy;
	logic           send_val;
	logic           send_rdy;
	cmul_pkg::fix_t ar;
	cmul_pkg::fix_t ac;
	cmul_pkg::fix_t br;
	cmul_pkg::fix_t bc;
	cmul_pkg::fix_t cr;
	cmul_pkg::fix_t cc;
	cmul_pkg::fix_t exp_cr;
	cmul_pkg::fix_t exp_cc;
	int             checked;
	int             errors;

	cmul_pkg::fix_t t_ar [NUM_TESTS];
	cmul_pkg::fix_t t_ac [NUM_TESTS];
	cmul_pkg::fix_t t_br [NUM_TESTS];
	cmul_pkg::fix_t t_bc [NUM_TESTS];
	cmul_pkg::fix_t t_cr [NUM_TESTS];
	cmul_pkg::fix_t t_cc [NUM_TESTS];
	int             t_hold [NUM_TESTS];
	logic [31:0]    lcg_state;

	always #5 clk = ~clk;

	cmul_top UUT (
		.clk      (clk),
		.reset    (reset),
		.recv_val (recv_val),
		.recv_rdy (recv_rdy),
		.ar       (ar),
		.ac       (ac),
		.br       (br),
		.bc       (bc),
		.send_val (send_val),
		.send_rdy (send_rdy),
		.cr       (cr),
		.cc       (cc)
	);

	bind cmul_top cmul_checker u_checker (
		.clk      (clk),
		.reset    (reset),
		.recv_rdy (recv_rdy),
		.send_val (send_val),
		.send_rdy (send_rdy),
		.cr       (cr),
		.cc       (cc)
	);

	cmul_monitor u_monitor (
		.clk      (clk),
		.reset    (reset),
		.recv_val (recv_val),
		.recv_rdy (recv_rdy),
		.send_val (send_val),
		.send_rdy (send_rdy),
		.cr       (cr),
		.cc       (cc),
		.exp_cr   (exp_cr),
		.exp_cc   (exp_cc),
		.checked  (checked),
		.errors   (errors)
	);

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// full signed product, floor of p / 2^D, low N bits kept.
	function automatic cmul_pkg::fix_t fixed_mul(input cmul_pkg::fix_t a, input cmul_pkg::fix_t b);
		logic [2*`CMUL_N-1:0] p;
		p = {{`CMUL_N{a[`CMUL_N-1]}}, a} * {{`CMUL_N{b[`CMUL_N-1]}}, b};
		return p[`CMUL_N+`CMUL_D-1:`CMUL_D];
	endfunction

	function automatic void complex_expected(input cmul_pkg::fix_t xr, input cmul_pkg::fix_t xc,
			input cmul_pkg::fix_t yr, input cmul_pkg::fix_t yc,
			output cmul_pkg::fix_t zr, output cmul_pkg::fix_t zc);
		cmul_pkg::fix_t p_sum;
		cmul_pkg::fix_t p_re;
		cmul_pkg::fix_t p_im;
		p_sum = fixed_mul(xr + xc, yr + yc); // both sums wrap at N bits.
		p_re  = fixed_mul(xr, yr);
		p_im  = fixed_mul(xc, yc);
		zr    = p_re - p_im;
		zc    = p_sum - p_re - p_im;
	endfunction

	task set_row(input int i, input cmul_pkg::fix_t xr, input cmul_pkg::fix_t xc,
			input cmul_pkg::fix_t yr, input cmul_pkg::fix_t yc, input int hold,
			input cmul_pkg::fix_t zr, input cmul_pkg::fix_t zc);
		t_ar[i]   = xr;
		t_ac[i]   = xc;
		t_br[i]   = yr;
		t_bc[i]   = yc;
		t_hold[i] = hold;
		t_cr[i]   = zr;
		t_cc[i]   = zc;
	endtask

	// values are Q15.16: 32'h0001_0000 is 1.0.
	task load_table();
		set_row(0, 32'h0001_0000, 32'h0, 32'h0001_0000, 32'h0, 0, 32'h0001_0000, 32'h0);
		set_row(1, 32'h0001_8000, 32'h0002_0000, 32'h0000_8000, 32'hffff_0000, 3,
			32'h0002_c000, 32'hffff_8000);
		set_row(2, 32'hffff_0000, 32'hffff_0000, 32'hffff_0000, 32'h0001_0000, 0,
			32'h0002_0000, 32'h0);
		set_row(3, 32'h0, 32'h0001_0000, 32'h0, 32'h0001_0000, 5, 32'hffff_0000, 32'h0);
		set_row(4, 32'hffff_ffff, 32'h0, 32'h0000_8000, 32'h0, 1, 32'hffff_ffff, 32'h0);
		set_row(5, 32'h0000_0003, 32'h0000_0001, 32'h0000_8000, 32'h0000_8000, 0,
			32'h0000_0001, 32'h0000_0003);
		set_row(6, 32'h0002_8000, 32'hffff_c000, 32'hfffd_0000, 32'h0004_0000, 7,
			32'hfff9_8000, 32'h000a_c000);
		set_row(7, 32'h0, 32'h0, 32'h0, 32'h0, 2, 32'h0, 32'h0);
		set_row(8, 32'h7fff_0000, 32'h7fff_0000, 32'h0001_0000, 32'h0001_0000, 4,
			32'h0, 32'hfffe_0000);
	endtask

	task fill_random();
		for (int i = NUM_TABLE; i < NUM_TESTS; i++) begin
			t_ar[i] = lcg_next();
			t_ac[i] = lcg_next();
			t_br[i] = lcg_next();
			t_bc[i] = lcg_next();
			if (i % 2 == 1) begin
				// smaller magnitudes, so these rows do not only test wrapping.
				t_ar[i] = $signed(t_ar[i]) >>> 12;
				t_ac[i] = $signed(t_ac[i]) >>> 12;
				t_br[i] = $signed(t_br[i]) >>> 12;
				t_bc[i] = $signed(t_bc[i]) >>> 12;
			end
			t_hold[i] = int'(lcg_next() % 32'(MAX_HOLD + 1));
			complex_expected(t_ar[i], t_ac[i], t_br[i], t_bc[i], t_cr[i], t_cc[i]);
		end
	endtask

	task drive_row(input int i);
		ar       = t_ar[i];
		ac       = t_ac[i];
		br       = t_br[i];
		bc       = t_bc[i];
		exp_cr   = t_cr[i];
		exp_cc   = t_cc[i];
		recv_val = 1'b1;
	endtask

	task run_test(input int i);
		while (!recv_rdy) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk); // the DUT takes the operands here.
		#1;
		recv_val = 1'b0;
		while (!send_val) begin
			@(posedge clk);
			#1;
		end
		if (i + 1 < NUM_TESTS)
			drive_row(i + 1); // offered early, it must wait for the result to leave.
		repeat (t_hold[i]) begin
			@(posedge clk);
			#1;
		end
		send_rdy = 1'b1;
		@(posedge clk);
		#1;
		send_rdy = 1'b0;
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		recv_val  = 1'b0;
		send_rdy  = 1'b0;
		ar        = '0;
		ac        = '0;
		br        = '0;
		bc        = '0;
		exp_cr    = '0;
		exp_cc    = '0;
		lcg_state = 32'h3c91_aef5;
		load_table();
		fill_random();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		drive_row(0);
		for (int i = 0; i < NUM_TESTS; i++)
			run_test(i);
		repeat (2) @(posedge clk);
		$display("%0d of %0d tests checked, %0d errors", checked, NUM_TESTS, errors);
		if (errors == 0 && checked == NUM_TESTS)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) @(posedge clk);
		$display("run timed out: the tests did not finish within %0d cycles",
			RESET_CYCLES + NUM_TESTS * TEST_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: rtl/cmul_operand_regs.sv
module cmul_operand_regs (
	input  logic              clk,
	input  logic              reset,
	input  logic              accept,
	input  logic              last_step,
	input  cmul_pkg::stage_t  stage,
	input  cmul_pkg::fix_t    ar,
	input  cmul_pkg::fix_t    ac,
	input  cmul_pkg::fix_t    br,
	input  cmul_pkg::fix_t    bc,
	input  cmul_pkg::fix_t    product,
	output cmul_pkg::fix_t    mul_a,
	output cmul_pkg::fix_t    mul_b,
	output cmul_pkg::fix_t    cr,
	output cmul_pkg::fix_t    cc
);

	cmul_pkg::fix_t r_ar;  // holds ar*br once the real stage finishes.
	cmul_pkg::fix_t r_ac;  // holds ac*bc once the imaginary stage finishes.
	cmul_pkg::fix_t r_br;
	cmul_pkg::fix_t r_bc;
	cmul_pkg::fix_t r_sum; // (ar+ac)*(br+bc).

	always_ff @(posedge clk) begin
		if (reset) begin
			r_ar  <= '0;
			r_ac  <= '0;
			r_br  <= '0;
			r_bc  <= '0;
			r_sum <= '0;
		end else if (accept) begin
			r_ar <= ar;
			r_ac <= ac;
			r_br <= br;
			r_bc <= bc;
		end else if (last_step) begin
			case (stage)
				cmul_pkg::SUM_PROD:  r_sum <= product;
				cmul_pkg::REAL_PROD: r_ar  <= product;
				cmul_pkg::IMAG_PROD: r_ac  <= product;
				default: ;
			endcase
		end
	end

	// r_ac is only overwritten after the imaginary stage has loaded it.
	always_comb begin
		case (stage)
			cmul_pkg::SUM_PROD: begin
				mul_a = r_ar + r_ac; // wraps at N bits.
				mul_b = r_br + r_bc;
			end
			cmul_pkg::REAL_PROD: begin
				mul_a = r_ar;
				mul_b = r_br;
			end
			cmul_pkg::IMAG_PROD: begin
				mul_a = r_ac;
				mul_b = r_bc;
			end
			default: begin
				mul_a = '0;
				mul_b = '0;
			end
		endcase
	end

	assign cr = r_ar - r_ac;
	assign cc = r_sum - r_ar - r_ac; // Gauss trick, one multiply saved.

endmodule

// File: rtl/cmul_pkg.sv
`include "cmul_settings.svh"

package cmul_pkg;

	// one fixed-point word.
	typedef logic [`CMUL_N-1:0] fix_t;

	// accumulator and sign-extended multiplicand.
	typedef logic [`CMUL_ACC_W-1:0] acc_t;

	typedef logic [`CMUL_STEP_W-1:0] step_t;

	// which real product the shared multiplier is working on.
	typedef enum logic [1:0] {
		SUM_PROD,  // (ar+ac)*(br+bc).
		REAL_PROD, // ar*br.
		IMAG_PROD, // ac*bc.
		NO_PROD
	} stage_t;

	typedef enum logic [2:0] {
		IDLE,
		MUL_SUM,
		MUL_REAL,
		MUL_IMAG,
		DONE
	} seq_state_t;

endpackage

// File: rtl/cmul_sequencer.sv
module cmul_sequencer (
	input  logic                clk,
	input  logic                reset,
	input  logic                recv_val,
	output logic                recv_rdy,
	output logic                send_val,
	input  logic                send_rdy,
	input  logic                last_step,
	output logic                accept,
	output logic                run,
	output cmul_pkg::stage_t    stage
);

	cmul_pkg::seq_state_t state;
	cmul_pkg::seq_state_t next_state;

	always_comb begin
		next_state = state;
		case (state)
			cmul_pkg::IDLE: begin
				if (recv_val)
					next_state = cmul_pkg::MUL_SUM;
			end
			cmul_pkg::MUL_SUM: begin
				if (last_step)
					next_state = cmul_pkg::MUL_REAL;
			end
			cmul_pkg::MUL_REAL: begin
				if (last_step)
					next_state = cmul_pkg::MUL_IMAG;
			end
			cmul_pkg::MUL_IMAG: begin
				if (last_step)
					next_state = cmul_pkg::DONE;
			end
			cmul_pkg::DONE: begin
				if (send_rdy)
					next_state = cmul_pkg::IDLE; // result leaves on this edge.
			end
			default: next_state = cmul_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= cmul_pkg::IDLE;
		else
			state <= next_state;
	end

	// only one transaction is in flight, so the input side opens in IDLE alone.
	assign recv_rdy = (state == cmul_pkg::IDLE);
	assign send_val = (state == cmul_pkg::DONE);
	assign accept   = recv_rdy && recv_val;

	always_comb begin
		run   = 1'b1;
		stage = cmul_pkg::NO_PROD;
		case (state)
			cmul_pkg::MUL_SUM:  stage = cmul_pkg::SUM_PROD;
			cmul_pkg::MUL_REAL: stage = cmul_pkg::REAL_PROD;
			cmul_pkg::MUL_IMAG: stage = cmul_pkg::IMAG_PROD;
			default:            run = 1'b0;
		endcase
	end

endmodule

// File: rtl/cmul_settings.svh
`ifndef CMUL_SETTINGS_SVH
`define CMUL_SETTINGS_SVH

// word width of every operand and result.
`define CMUL_N 32

// fraction bits in each word; the binary point sits below bit CMUL_D.
`define CMUL_D 16

// the accumulator carries D extra bits below the kept product.
`define CMUL_ACC_W (`CMUL_N + `CMUL_D)

// step counter width, wide enough to count 0 through N.
`define CMUL_STEP_W $clog2(`CMUL_N + 1)

`endif

// File: rtl/cmul_top.sv
module cmul_top (
	input  logic            clk,
	input  logic            reset,
	input  logic            recv_val,
	output logic            recv_rdy,
	input  cmul_pkg::fix_t  ar,
	input  cmul_pkg::fix_t  ac,
	input  cmul_pkg::fix_t  br,
	input  cmul_pkg::fix_t  bc,
	output logic            send_val,
	input  logic            send_rdy,
	output cmul_pkg::fix_t  cr,
	output cmul_pkg::fix_t  cc
);

	logic             accept;
	logic             run;
	logic             load;
	logic             last_step;
	cmul_pkg::stage_t stage;
	cmul_pkg::fix_t   mul_a;
	cmul_pkg::fix_t   mul_b;
	cmul_pkg::fix_t   product;

	cmul_sequencer u_seq (
		.clk       (clk),
		.reset     (reset),
		.recv_val  (recv_val),
		.recv_rdy  (recv_rdy),
		.send_val  (send_val),
		.send_rdy  (send_rdy),
		.last_step (last_step),
		.accept    (accept),
		.run       (run),
		.stage     (stage)
	);

	mul_step_counter u_cnt (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.load      (load),
		.last_step (last_step)
	);

	shift_add_datapath u_mul (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.last_step (last_step),
		.mul_a     (mul_a),
		.mul_b     (mul_b),
		.product   (product)
	);

	cmul_operand_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.accept    (accept),
		.last_step (last_step),
		.stage     (stage),
		.ar        (ar),
		.ac        (ac),
		.br        (br),
		.bc        (bc),
		.product   (product),
		.mul_a     (mul_a),
		.mul_b     (mul_b),
		.cr        (cr),
		.cc        (cc)
	);

endmodule

// File: rtl/mul_step_counter.sv
`include "cmul_settings.svh"

module mul_step_counter (
	input  logic clk,
	input  logic reset,
	input  logic run,
	output logic load,
	output logic last_step
);

	cmul_pkg::step_t step;

	// step 0 loads the operands, steps 1 to N each retire one multiplier bit.
	assign load      = run && (step == '0);
	assign last_step = run && (step == cmul_pkg::step_t'(`CMUL_N));

	always_ff @(posedge clk) begin
		if (reset || !run)
			step <= '0;
		else if (last_step)
			step <= '0; // next product starts with a fresh load.
		else
			step <= step + cmul_pkg::step_t'(1);
	end

endmodule

// File: rtl/shift_add_datapath.sv
`include "cmul_settings.svh"

module shift_add_datapath (
	input  logic            clk,
	input  logic            reset,
	input  logic            load,
	input  logic            last_step,
	input  cmul_pkg::fix_t  mul_a,
	input  cmul_pkg::fix_t  mul_b,
	output cmul_pkg::fix_t  product
);

	cmul_pkg::acc_t a_ext;
	cmul_pkg::acc_t mcand;  // shifts left one place per step.
	cmul_pkg::acc_t a_orig; // unshifted copy for the sign correction.
	cmul_pkg::fix_t mplier; // shifts right, bit 0 decides each add.
	cmul_pkg::acc_t acc;
	cmul_pkg::acc_t acc_next;
	cmul_pkg::acc_t corr;
	cmul_pkg::acc_t addend;

	assign a_ext = {{`CMUL_D{mul_a[`CMUL_N-1]}}, mul_a};

	// the top multiplier bit weighs -2^(N-1), so the last step subtracts
	// the multiplicand at that weight instead of adding it.
	assign corr   = -(a_orig << (`CMUL_N - 1));
	assign addend = last_step ? corr : mcand;

	always_comb begin
		acc_next = acc;
		if (load)
			acc_next = '0;
		else if (mplier[0])
			acc_next = acc + addend;
	end

	// bits above N+D are dropped; the low D bits are the floor rounding.
	assign product = acc_next[`CMUL_ACC_W-1:`CMUL_D];

	always_ff @(posedge clk) begin
		if (reset) begin
			acc    <= '0;
			mplier <= '0;
		end else begin
			acc <= acc_next;
			if (load)
				mplier <= mul_b;
			else
				mplier <= mplier >> 1;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			mcand  <= a_ext;
			a_orig <= a_ext;
		end else begin
			mcand <= mcand << 1;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cmul_tb -f cmul.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vcmul_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
echo "pass line not found in the simulation output"
exit 1
